//--- cache_sub.f
design/cache_geom_pkg.sv
design/cache_bus_pkg.sv
design/cache_way_if.sv
design/cache_way.sv
design/cache_way_select.sv
design/cache_control.sv
design/cache_top.sv
dv/cache_tb.sv

//--- Bender.yml
package:
  name: cache_sub

sources:
  - design/cache_geom_pkg.sv
  - design/cache_bus_pkg.sv
  - design/cache_way_if.sv
  - design/cache_way.sv
  - design/cache_way_select.sv
  - design/cache_control.sv
  - design/cache_top.sv
  - target: test
    files:
      - dv/cache_tb.sv

//--- dv/cache_tb.sv
`timescale 1ns/100ps

module cache_tb;
	localparam int N_READS   = 150;
	localparam int N_WR_ROUNDS = 150;
	localparam int N_MIXED   = 200;
	localparam int N_OPS     = N_READS + 3 * N_WR_ROUNDS + N_MIXED;
	// Write-back plus fill with the longest ack delay, plus lookups
	localparam int WORST_CYC = 30;

	logic clk, reset, cyc, stb, we, ack, mem_cyc, mem_stb, mem_we, mem_ack;
	logic [15:0]  adr, dat_w, dat_r;
	logic [11:0]  mem_adr;
	logic [127:0] mem_dat_w, mem_dat_r;

	integer seed = 32'h7f80;
	int errors = 0;
	int tests_ok = 0;
	int tests_bad = 0;

	// Backing memory and the processor's view of it
	logic [127:0] backing [4096];
	logic [15:0]  view [65536];

	// Model of the cache state per set and way
	logic       m_valid [8][2];
	logic       m_dirty [8][2];
	logic [8:0] m_tag [8][2];
	logic       m_lru [8];
	logic [8:0] tag_pool [4];

	// Memory transfers seen by the responder
	logic         ev_we [$];
	logic [11:0]  ev_adr [$];
	logic [127:0] ev_data [$];

	int delay_cnt;
	logic         prev_hold;
	logic         prev_we;
	logic [11:0]  prev_adr;
	logic [127:0] prev_dat;

	cache_top dut_i (
		.clk, .reset, .cyc, .stb, .we, .adr, .dat_w, .ack, .dat_r,
		.mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_dat_w, .mem_ack, .mem_dat_r
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] got);
		if (exp !== got) begin
			$display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		if (errors == err_before) begin
			tests_ok++;
			$display("test %s: ok", name);
		end else begin
			tests_bad++;
			$display("test %s: failed with %0d errors", name, errors - err_before);
		end
	endtask

	task automatic check_idle_outputs();
		check_val("ack", 0, ack);
		check_val("mem_cyc", 0, mem_cyc);
		check_val("mem_stb", 0, mem_stb);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Memory responder and hold check
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(posedge clk) begin
		if (reset) begin
			mem_ack <= 1'b0;
			delay_cnt = -1;
		end else if (mem_ack) begin
			mem_ack <= 1'b0;
		end else if (mem_stb) begin
			if (delay_cnt < 0) delay_cnt = {$random(seed)} % 6;
			if (delay_cnt == 0) begin
				mem_ack <= 1'b1;
				ev_we.push_back(mem_we);
				ev_adr.push_back(mem_adr);
				ev_data.push_back(mem_dat_w);
				if (mem_we) backing[mem_adr] = mem_dat_w;
				else mem_dat_r <= backing[mem_adr];
				delay_cnt = -1;
			end else begin
				delay_cnt--;
			end
		end
	end

	always @(posedge clk) begin
		if (!reset && mem_stb) check_val("mem_cyc", 1, mem_cyc);
		if (!reset && prev_hold) begin
			if (!mem_stb) begin
				$display("Memory strobe dropped before ack at t=%0t", $time);
				errors++;
			end
			check_val("mem_we", prev_we, mem_we);
			check_val("mem_adr", prev_adr, mem_adr);
			check_val("mem_dat_w", prev_dat, mem_dat_w);
		end
		prev_hold = !reset && mem_stb && !mem_ack;
		prev_we   = mem_we;
		prev_adr  = mem_adr;
		prev_dat  = mem_dat_w;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// One processor access, checked against the model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic run_access(input logic w, input logic [15:0] a, input logic [15:0] d);
		int cycles;
		int way;
		int v;
		logic [2:0] set;
		logic [8:0] tag;
		logic vdirty;
		logic [127:0] wb_line;
		logic [15:0] got;
		set = a[6:4];
		tag = a[15:7];
		way = -1;
		for (int i = 0; i < 2; i++) begin
			if (m_valid[set][i] && m_tag[set][i] == tag) way = i;
		end
		v = m_lru[set];
		vdirty = m_valid[set][v] && m_dirty[set][v];
		for (int i = 0; i < 8; i++) begin
			wb_line[i*16 +: 16] = view[{m_tag[set][v], set, i[2:0], 1'b0}];
		end
		ev_we.delete();
		ev_adr.delete();
		ev_data.delete();
		@(posedge clk);
		cyc   <= 1'b1;
		stb   <= 1'b1;
		we    <= w;
		adr   <= a;
		dat_w <= d;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (!ack);
		got = dat_r;
		cyc <= 1'b0;
		stb <= 1'b0;
		we  <= 1'b0;
		if (!w) check_val("dat_r", view[{a[15:1], 1'b0}], got);
		if (way >= 0) begin
			check_val("hit latency", 2, cycles);
			check_val("memory transfers on hit", 0, ev_we.size());
		end else if (vdirty) begin
			check_val("memory transfers on dirty miss", 2, ev_we.size());
			if (ev_we.size() == 2) begin
				check_val("mem_we", 1, ev_we[0]);
				check_val("mem_adr", {m_tag[set][v], set}, ev_adr[0]);
				check_val("mem_dat_w", wb_line, ev_data[0]);
				check_val("mem_we", 0, ev_we[1]);
				check_val("mem_adr", {tag, set}, ev_adr[1]);
			end
		end else begin
			check_val("memory transfers on clean miss", 1, ev_we.size());
			if (ev_we.size() == 1) begin
				check_val("mem_we", 0, ev_we[0]);
				check_val("mem_adr", {tag, set}, ev_adr[0]);
			end
		end
		// Model update, a miss fills the LRU way
		if (way < 0) begin
			way = v;
			m_valid[set][way] = 1'b1;
			m_dirty[set][way] = 1'b0;
			m_tag[set][way]   = tag;
		end
		m_lru[set] = !way[0];
		if (w) begin
			m_dirty[set][way] = 1'b1;
			view[{a[15:1], 1'b0}] = d;
		end
	endtask

	function automatic logic [15:0] pool_addr(input int t);
		return {tag_pool[t], 3'({$random(seed)}), 3'({$random(seed)}), 1'b0};
	endfunction

	initial begin
		#(N_OPS * WORST_CYC * 20 + 1000);
		$display("Timeout, the run did not finish in time");
		$display("TB FAILED");
		$finish;
	end

	initial begin
		int e0;
		int t;
		logic [15:0] a;
		logic [15:0] d;
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		mem_ack = 1'b0;
		mem_dat_r = '0;
		for (int l = 0; l < 4096; l++) begin
			backing[l] = {$random(seed), $random(seed), $random(seed), $random(seed)};
			for (int i = 0; i < 8; i++) view[{l[11:0], i[2:0], 1'b0}] = backing[l][i*16 +: 16];
		end
		for (int s = 0; s < 8; s++) begin
			m_lru[s] = 1'b0;
			for (int i = 0; i < 2; i++) begin
				m_valid[s][i] = 1'b0;
				m_dirty[s][i] = 1'b0;
				m_tag[s][i] = '0;
			end
		end
		for (int i = 0; i < 4; i++) tag_pool[i] = 9'($random(seed));

		// Outputs looked at mid-cycle, after the reset edge has settled
		e0 = errors;
		for (int c = 0; c < 3; c++) begin
			@(posedge clk);
			if (c == 2) reset <= 1'b0;
			@(negedge clk);
			check_idle_outputs();
		end
		@(posedge clk);
		@(negedge clk);
		check_idle_outputs();
		finish_test("reset", e0);

		e0 = errors;
		repeat (N_READS) run_access(1'b0, pool_addr({$random(seed)} % 4), 16'h0);
		finish_test("random_reads", e0);

		// Write, read back, then read a conflicting tag in the same set
		e0 = errors;
		repeat (N_WR_ROUNDS) begin
			t = {$random(seed)} % 4;
			a = pool_addr(t);
			d = 16'($random(seed));
			run_access(1'b1, a, d);
			run_access(1'b0, a, 16'h0);
			t = (t + 1 + {$random(seed)} % 3) % 4;
			run_access(1'b0, {tag_pool[t], a[6:0]}, 16'h0);
		end
		finish_test("write_readback", e0);

		e0 = errors;
		repeat (N_MIXED) begin
			run_access(1'($random(seed)), pool_addr({$random(seed)} % 4), 16'($random(seed)));
		end
		finish_test("mixed_backpressure", e0);

		$display("tests ok %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- design/cache_top.sv
`timescale 1ns/100ps

module cache_top (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                cyc,
	input  logic                                stb,
	input  logic                                we,
	input  logic [cache_bus_pkg::ADDR_W-1:0]    adr,
	input  logic [cache_bus_pkg::DATA_W-1:0]    dat_w,
	output logic                                ack,
	output logic [cache_bus_pkg::DATA_W-1:0]    dat_r,
	output logic                                mem_cyc,
	output logic                                mem_stb,
	output logic                                mem_we,
	output logic [cache_bus_pkg::MEM_ADR_W-1:0] mem_adr,
	output logic [cache_bus_pkg::LINE_W-1:0]    mem_dat_w,
	input  logic                                mem_ack,
	input  logic [cache_bus_pkg::LINE_W-1:0]    mem_dat_r
);
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;

	// Selector to controller
	logic              any_hit;
	logic [WAY_W-1:0]  hit_way;
	logic [WAY_W-1:0]  victim_way;
	logic              victim_dirty;
	logic [TAG_W-1:0]  victim_tag;
	logic [LINE_W-1:0] rd_line_hit;
	logic [LINE_W-1:0] victim_line;
	logic              lru_touch;

	cache_way_if way_bus [NUM_WAYS] ();

	cache_control control_i (
		.clk, .reset,
		.cyc, .stb, .we, .adr, .dat_w, .ack, .dat_r,
		.mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_dat_w, .mem_ack, .mem_dat_r,
		.any_hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
		.rd_line_hit, .victim_line, .lru_touch,
		.way_bus (way_bus)
	);

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		cache_way way_i (
			.clk,
			.reset,
			.bus (way_bus[w])
		);
	end

	// Every way is addressed with the same set
	cache_way_select select_i (
		.clk, .reset,
		.set (way_bus[0].set),
		.lru_touch,
		.any_hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
		.rd_line_hit, .victim_line,
		.way_bus (way_bus)
	);

endmodule

//--- design/cache_control.sv
`timescale 1ns/100ps

module cache_control (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              cyc,
	input  logic                              stb,
	input  logic                              we,
	input  logic [cache_bus_pkg::ADDR_W-1:0]  adr,
	input  logic [cache_bus_pkg::DATA_W-1:0]  dat_w,
	output logic                              ack,
	output logic [cache_bus_pkg::DATA_W-1:0]  dat_r,
	output logic                              mem_cyc,
	output logic                              mem_stb,
	output logic                              mem_we,
	output logic [cache_bus_pkg::MEM_ADR_W-1:0] mem_adr,
	output logic [cache_bus_pkg::LINE_W-1:0]  mem_dat_w,
	input  logic                              mem_ack,
	input  logic [cache_bus_pkg::LINE_W-1:0]  mem_dat_r,
	input  logic                              any_hit,
	input  logic [cache_geom_pkg::WAY_W-1:0]  hit_way,
	input  logic [cache_geom_pkg::WAY_W-1:0]  victim_way,
	input  logic                              victim_dirty,
	input  logic [cache_geom_pkg::TAG_W-1:0]  victim_tag,
	input  logic [cache_bus_pkg::LINE_W-1:0]  rd_line_hit,
	input  logic [cache_bus_pkg::LINE_W-1:0]  victim_line,
	output logic                              lru_touch,
	cache_way_if.ctrl                         way_bus [cache_geom_pkg::NUM_WAYS]
);
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;

	typedef enum logic [1:0] {IDLE, LOOKUP, WRITEBACK, FILL} state_e;

	state_e state, next_state;

	// Latched request
	logic              req_we;
	logic [TAG_W-1:0]  req_tag;
	logic [SET_W-1:0]  req_set;
	logic [OFS_W-1:0]  req_ofs;
	logic [DATA_W-1:0] req_wdata;

	way_op_e           cmd_op;
	logic [WAY_W-1:0]  cmd_way;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (cyc && stb) next_state = LOOKUP;
			end
			LOOKUP: begin
				if (any_hit) next_state = IDLE;
				else if (victim_dirty) next_state = WRITEBACK;
				else next_state = FILL;
			end
			WRITEBACK: begin
				if (mem_ack) next_state = FILL;
			end
			FILL: begin
				// Retry lookup once the line is in
				if (mem_stb && mem_ack) next_state = LOOKUP;
			end
			default: next_state = IDLE;
		endcase
	end

	// Processor ack, LRU update and way commands
	always_comb begin
		ack       = 1'b0;
		lru_touch = 1'b0;
		cmd_op    = WAY_NONE;
		cmd_way   = hit_way;
		case (state)
			LOOKUP: begin
				if (any_hit) begin
					ack       = 1'b1;
					lru_touch = 1'b1;
					if (req_we) cmd_op = WAY_WRITE_WORD;
				end
			end
			WRITEBACK: begin
				if (mem_ack) begin
					cmd_op  = WAY_CLEAN;
					cmd_way = victim_way;
				end
			end
			FILL: begin
				if (mem_stb && mem_ack) begin
					cmd_op  = WAY_FILL;
					cmd_way = victim_way;
				end
			end
			default: ;
		endcase
	end

	assign dat_r = rd_line_hit[req_ofs*DATA_W +: DATA_W];

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= IDLE;
			mem_cyc <= 1'b0;
			mem_stb <= 1'b0;
			mem_we  <= 1'b0;
		end else begin
			state <= next_state;
			case (state)
				LOOKUP: begin
					if (!any_hit) begin
						mem_cyc <= 1'b1;
						mem_stb <= 1'b1;
						mem_we  <= victim_dirty;
					end
				end
				WRITEBACK: begin
					if (mem_ack) begin
						mem_cyc <= 1'b0;
						mem_stb <= 1'b0;
						mem_we  <= 1'b0;
					end
				end
				FILL: begin
					// Entered from write-back with the bus idle
					if (!mem_stb) begin
						mem_cyc <= 1'b1;
						mem_stb <= 1'b1;
						mem_we  <= 1'b0;
					end else if (mem_ack) begin
						mem_cyc <= 1'b0;
						mem_stb <= 1'b0;
					end
				end
				default: ;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Request and memory payload
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (state == IDLE && cyc && stb) begin
			req_we    <= we;
			req_tag   <= adr[ADDR_W-1 -: TAG_W];
			req_set   <= adr[OFS_W+1 +: SET_W];
			req_ofs   <= adr[1 +: OFS_W];
			req_wdata <= dat_w;
		end
		if (state == LOOKUP && !any_hit) begin
			mem_adr   <= victim_dirty ? {victim_tag, req_set} : {req_tag, req_set};
			mem_dat_w <= victim_line;
		end
		if (state == FILL && !mem_stb) begin
			mem_adr <= {req_tag, req_set};
		end
	end

	// Only the selected way sees a command
	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way_cmd
		assign way_bus[w].op        = (cmd_way == WAY_W'(w)) ? cmd_op : WAY_NONE;
		assign way_bus[w].set       = req_set;
		assign way_bus[w].tag       = req_tag;
		assign way_bus[w].ofs       = req_ofs;
		assign way_bus[w].wdata     = req_wdata;
		assign way_bus[w].fill_line = mem_dat_r;
	end

	a_ack_in_cycle: assert property (
		@(posedge clk) disable iff (reset)
		ack |-> cyc && stb
	);

	a_stb_in_cyc: assert property (
		@(posedge clk) disable iff (reset)
		mem_stb |-> mem_cyc
	);

	// Memory request held until the slave answers
	a_mem_hold: assert property (
		@(posedge clk) disable iff (reset)
		mem_stb && !mem_ack |=> mem_stb && $stable(mem_we) && $stable(mem_adr)
			&& $stable(mem_dat_w)
	);

endmodule

//--- design/cache_way_select.sv
`timescale 1ns/100ps

module cache_way_select (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [cache_geom_pkg::SET_W-1:0]    set,
	input  logic                                lru_touch,
	output logic                                any_hit,
	output logic [cache_geom_pkg::WAY_W-1:0]    hit_way,
	output logic [cache_geom_pkg::WAY_W-1:0]    victim_way,
	output logic                                victim_dirty,
	output logic [cache_geom_pkg::TAG_W-1:0]    victim_tag,
	output logic [cache_bus_pkg::LINE_W-1:0]    rd_line_hit,
	output logic [cache_bus_pkg::LINE_W-1:0]    victim_line,
	cache_way_if.sel                            way_bus [cache_geom_pkg::NUM_WAYS]
);
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;

	logic [NUM_WAYS-1:0] hit_vec;
	logic [NUM_WAYS-1:0] dirty_vec;
	logic [TAG_W-1:0]    tag_vec [NUM_WAYS];
	logic [LINE_W-1:0]   line_vec [NUM_WAYS];

	// One bit per set, names the least recently used way
	logic [NUM_SETS-1:0] lru_q;

	// Flatten the interface array so it can be indexed at run time
	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_gather
		assign hit_vec[w]   = way_bus[w].hit;
		assign dirty_vec[w] = way_bus[w].dirty;
		assign tag_vec[w]   = way_bus[w].victim_tag;
		assign line_vec[w]  = way_bus[w].rd_line;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Hit side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign any_hit = |hit_vec;

	always_comb begin
		hit_way = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (hit_vec[w]) begin
				hit_way = WAY_W'(w);
			end
		end
	end

	assign rd_line_hit = line_vec[hit_way];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Replacement side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign victim_way   = lru_q[set];
	assign victim_dirty = dirty_vec[victim_way];
	assign victim_tag   = tag_vec[victim_way];
	assign victim_line  = line_vec[victim_way];

	// Accessed way becomes MRU, so the other one is next to go
	always_ff @(posedge clk) begin
		if (reset) begin
			lru_q <= '0;
		end else if (lru_touch) begin
			lru_q[set] <= ~hit_way;
		end
	end

	a_one_hit: assert property (
		@(posedge clk) disable iff (reset)
		$onehot0(hit_vec)
	);

endmodule

//--- design/cache_way.sv
`timescale 1ns/100ps

module cache_way (
	input logic  clk,
	input logic  reset,
	cache_way_if.way bus
);
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;

	logic [NUM_SETS-1:0] valid_q;
	logic [NUM_SETS-1:0] dirty_q;
	logic [TAG_W-1:0]    tag_q [NUM_SETS];
	logic [LINE_W-1:0]   line_q [NUM_SETS];

	logic [LINE_W-1:0] merged_line;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Lookup
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign bus.hit        = valid_q[bus.set] && (tag_q[bus.set] == bus.tag);
	assign bus.dirty      = valid_q[bus.set] && dirty_q[bus.set];
	assign bus.victim_tag = tag_q[bus.set];
	assign bus.rd_line    = line_q[bus.set];

	// Stored line with the new word dropped in at the offset
	always_comb begin
		merged_line = line_q[bus.set];
		merged_line[bus.ofs*DATA_W +: DATA_W] = bus.wdata;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// State update
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			case (bus.op)
				WAY_FILL: begin
					valid_q[bus.set] <= 1'b1;
					dirty_q[bus.set] <= 1'b0;
				end
				WAY_WRITE_WORD: begin
					dirty_q[bus.set] <= 1'b1;
				end
				WAY_CLEAN: begin
					dirty_q[bus.set] <= 1'b0;
				end
				default: ;
			endcase
		end
	end

	// Tag and data arrays
	always_ff @(posedge clk) begin
		case (bus.op)
			WAY_FILL: begin
				tag_q[bus.set]  <= bus.tag;
				line_q[bus.set] <= bus.fill_line;
			end
			WAY_WRITE_WORD: begin
				line_q[bus.set] <= merged_line;
			end
			default: ;
		endcase
	end

	// Controller writes words only into the way that reported the hit
	a_write_on_hit: assert property (
		@(posedge clk) disable iff (reset)
		bus.op == WAY_WRITE_WORD |-> bus.hit
	);

endmodule

//--- design/cache_way_if.sv
`timescale 1ns/100ps

interface cache_way_if;
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;

	// Command side
	way_op_e           op;
	logic [SET_W-1:0]  set;
	logic [TAG_W-1:0]  tag;
	logic [OFS_W-1:0]  ofs;
	logic [DATA_W-1:0] wdata;
	logic [LINE_W-1:0] fill_line;

	// Lookup results for the addressed set
	logic              hit;
	logic              dirty;
	logic [TAG_W-1:0]  victim_tag;
	logic [LINE_W-1:0] rd_line;

	modport ctrl (
		output op, set, tag, ofs, wdata, fill_line
	);

	modport way (
		input  op, set, tag, ofs, wdata, fill_line,
		output hit, dirty, victim_tag, rd_line
	);

	modport sel (
		input hit, dirty, victim_tag, rd_line
	);

endinterface

//--- design/cache_bus_pkg.sv
package cache_bus_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Processor side Wishbone
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int ADDR_W = 16;
	localparam int DATA_W = 16;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Memory side Wishbone, one line per transfer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Line address is tag followed by set
	localparam int MEM_ADR_W = 12;

	localparam int LINE_W = 128;

endpackage

//--- design/cache_geom_pkg.sv
package cache_geom_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address split: tag | set | word offset | ignored bit 0
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int TAG_W = 9;
	localparam int SET_W = 3;
	localparam int OFS_W = 3;

	localparam int NUM_SETS   = 8;
	localparam int LINE_WORDS = 8;

	// Two ways only, the LRU is a single bit per set
	localparam int NUM_WAYS = 2;
	localparam int WAY_W    = 1;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Command to a single way
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [1:0] {
		// No change
		WAY_NONE,
		// Load line from memory, valid set, dirty cleared, tag stored
		WAY_FILL,
		// Merge one word at the offset, mark dirty
		WAY_WRITE_WORD,
		// Dirty cleared after write-back
		WAY_CLEAN
	} way_op_e;

endpackage
